// File: build.f
+incdir+include
src/lsu_pkg.sv
src/lsu_access_ctrl.sv
src/lsu_data_mem.sv
src/lsu_io_regs.sv
src/lsu_load_extract.sv
src/lsu_top.sv
dv/tb_clkgen.sv
dv/tb_lsu.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps
TOP      := tb_lsu
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_lsu.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module tb_lsu;

    localparam int RESET_TIMEOUT = 50;
    localparam int T_NONE  = 0;
    localparam int T_MEM   = 1;
    localparam int T_LEDR  = 2;
    localparam int T_LEDG  = 3;
    localparam int T_HEXLO = 4;
    localparam int T_HEXHI = 5;
    localparam int T_SW    = 6;

    logic             clk;
    logic             rst;
    logic             lsu_wren;
    lsu_pkg::word_t   lsu_addr;
    lsu_pkg::word_t   st_data;
    lsu_pkg::word_t   io_sw;
    lsu_pkg::mem_op_e op;
    lsu_pkg::word_t   ld_data;
    lsu_pkg::word_t   io_ledr;
    lsu_pkg::word_t   io_ledg;
    lsu_pkg::seg_t    hex [8];

    // Reference model state
    lsu_pkg::word_t   mem_m [`LSU_MEM_DEPTH];
    lsu_pkg::word_t   ledr_m;
    lsu_pkg::word_t   ledg_m;
    lsu_pkg::seg_t    hex_m [8];
    lsu_pkg::word_t   sw_m;
    integer           seed;
    int               errors;
    int               checks;
    bit               reset_done;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_reset (rst)
    );

    lsu_top DUT (
        .i_clk      (clk),
        .i_reset    (rst),
        .i_lsu_wren (lsu_wren),
        .i_lsu_addr (lsu_addr),
        .i_st_data  (st_data),
        .i_io_sw    (io_sw),
        .i_type     (op),
        .o_ld_data  (ld_data),
        .o_io_ledr  (io_ledr),
        .o_io_ledg  (io_ledg),
        .o_io_hex0  (hex[0]),
        .o_io_hex1  (hex[1]),
        .o_io_hex2  (hex[2]),
        .o_io_hex3  (hex[3]),
        .o_io_hex4  (hex[4]),
        .o_io_hex5  (hex[5]),
        .o_io_hex6  (hex[6]),
        .o_io_hex7  (hex[7])
    );

    function automatic int region_of(lsu_pkg::word_t a);
        if (a < 32'h0000_8000) return T_MEM;
        case (a[31:12])
            `LSU_LEDR_PAGE:  return T_LEDR;
            `LSU_LEDG_PAGE:  return T_LEDG;
            `LSU_HEXLO_PAGE: return T_HEXLO;
            `LSU_HEXHI_PAGE: return T_HEXHI;
            `LSU_SW_PAGE:    return T_SW;
            default:         return T_NONE;
        endcase
    endfunction

    // Word a load would see, seven-segment bit 7 reads as 0
    function automatic lsu_pkg::word_t model_word(lsu_pkg::word_t a);
        case (region_of(a))
            T_MEM:   return mem_m[a[9:2]];   // 1 KB alias
            T_LEDR:  return ledr_m;
            T_LEDG:  return ledg_m;
            T_HEXLO: return {1'b0, hex_m[3], 1'b0, hex_m[2], 1'b0, hex_m[1], 1'b0, hex_m[0]};
            T_HEXHI: return {1'b0, hex_m[7], 1'b0, hex_m[6], 1'b0, hex_m[5], 1'b0, hex_m[4]};
            T_SW:    return sw_m;
            default: return '0;
        endcase
    endfunction

    function automatic lsu_pkg::word_t load_expect(lsu_pkg::mem_op_e t, lsu_pkg::word_t a);
        lsu_pkg::word_t w;
        logic [7:0]     b;
        logic [15:0]    h;
        w = model_word(a);
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        if (region_of(a) == T_NONE) return '0;
        if (region_of(a) == T_SW) return w;
        case (t)
            lsu_pkg::LB:  return 32'($signed(b));
            lsu_pkg::LBU: return 32'(b);
            lsu_pkg::LH:  return 32'($signed(h));
            lsu_pkg::LHU: return 32'(h);
            default:      return w;
        endcase
    endfunction

    function automatic void store_model(lsu_pkg::mem_op_e t, lsu_pkg::word_t a,
                                        lsu_pkg::word_t d);
        logic [7:0] lane;
        bit         en;
        int         r;
        r = region_of(a);
        for (int i = 0; i < 4; i++) begin
            en   = 1'b0;
            lane = '0;
            case (t)
                lsu_pkg::SW: begin
                    en   = 1'b1;
                    lane = d[8*i +: 8];
                end
                lsu_pkg::SH: begin
                    en   = (i / 2 == int'(a[1]));
                    lane = d[8*(i%2) +: 8];
                end
                lsu_pkg::SB: begin
                    en   = (i == int'(a[1:0]));
                    lane = d[7:0];
                end
                default: en = 1'b0;
            endcase
            if (en) begin
                case (r)
                    T_MEM:   mem_m[a[9:2]][8*i +: 8] = lane;
                    T_LEDR:  ledr_m[8*i +: 8] = lane;
                    T_LEDG:  ledg_m[8*i +: 8] = lane;
                    T_HEXLO: hex_m[i] = lane[6:0];
                    T_HEXHI: hex_m[4 + i] = lane[6:0];
                    default: ;   // Switch page and unmapped space
                endcase
            end
        end
    endfunction

    function automatic lsu_pkg::word_t top_bits(lsu_pkg::word_t w, bit set);
        return set ? (w | 32'h8080_8080) : (w & 32'h7f7f_7f7f);
    endfunction

    task automatic check_word(string name, lsu_pkg::word_t got, lsu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_seg(string name, lsu_pkg::seg_t got, lsu_pkg::seg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic wait_reset_release(output bit released);
        int n;
        n = 0;
        while (rst !== 1'b0 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        released = (rst === 1'b0);
        if (!released) begin
            errors++;
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic drive(lsu_pkg::mem_op_e t, lsu_pkg::word_t a, lsu_pkg::word_t d, logic we);
        @(posedge clk);
        #1;
        op       = t;
        lsu_addr = a;
        st_data  = d;
        lsu_wren = we;
    endtask

    task automatic store(lsu_pkg::mem_op_e t, lsu_pkg::word_t a, lsu_pkg::word_t d);
        drive(t, a, d, 1'b1);
        store_model(t, a, d);
    endtask

    task automatic load_check(lsu_pkg::mem_op_e t, lsu_pkg::word_t a);
        lsu_pkg::word_t exp;
        exp = load_expect(t, a);
        drive(t, a, '0, 1'b0);
        @(negedge clk);
        check_word($sformatf("o_ld_data (%s @%h)", t.name(), a), ld_data, exp);
    endtask

    task automatic idle();
        drive(lsu_pkg::LW, '0, '0, 1'b0);
        @(negedge clk);
    endtask

    task automatic check_board();
        check_word("o_io_ledr", io_ledr, ledr_m);
        check_word("o_io_ledg", io_ledg, ledg_m);
        for (int i = 0; i < 8; i++) begin
            check_seg($sformatf("o_io_hex%0d", i), hex[i], hex_m[i]);
        end
    endtask

    // Memory is not reset, so it can hold a word while the load output is forced to 0
    task automatic test_in_reset();
        drive(lsu_pkg::SW, {`LSU_LEDR_PAGE, 12'h000}, 32'hffff_ffff, 1'b1);  // Held off by reset
        store(lsu_pkg::SW, 32'h10, 32'h5a3c_c3a5);
        drive(lsu_pkg::LW, 32'h10, '0, 1'b0);
        @(negedge clk);
        check_word("o_ld_data in reset", ld_data, '0);
    endtask

    task automatic test_reset();
        idle();
        check_board();
        load_check(lsu_pkg::LW, {`LSU_LEDR_PAGE, 12'h000});
        load_check(lsu_pkg::LW, {`LSU_LEDG_PAGE, 12'h000});
        load_check(lsu_pkg::LW, {`LSU_HEXLO_PAGE, 12'h000});
        load_check(lsu_pkg::LW, {`LSU_HEXHI_PAGE, 12'h000});
        load_check(lsu_pkg::LW, {`LSU_SW_PAGE, 12'h000});
        load_check(lsu_pkg::LW, 32'h10);
    endtask

    task automatic test_word_mem();
        lsu_pkg::word_t addrs [5];
        lsu_pkg::word_t old;
        addrs = '{32'h0, 32'h4, 32'h124, 32'h3fc, 32'h2a8};
        for (int i = 0; i < 5; i++) store(lsu_pkg::SW, addrs[i], $random(seed));
        for (int i = 0; i < 5; i++) load_check(lsu_pkg::LW, addrs[i]);
        load_check(lsu_pkg::LW, 32'h0000_7d24);   // Aliases 0x124
        // Store cycle still reads the old word
        old = mem_m[addrs[1][9:2]];
        store(lsu_pkg::SW, addrs[1], $random(seed));
        @(negedge clk);
        check_word("o_ld_data during store", ld_data, old);
        load_check(lsu_pkg::LW, addrs[1]);
    endtask

    task automatic test_partial();
        lsu_pkg::word_t base;
        base = 32'h200;
        for (int pass = 0; pass < 2; pass++) begin
            store(lsu_pkg::SW, base, top_bits($random(seed), pass == 0));
            for (int off = 0; off < 4; off++) begin
                store(lsu_pkg::SB, base + off, top_bits($random(seed), pass == 0));
                load_check(lsu_pkg::LW, base);
            end
            store(lsu_pkg::SH, base, top_bits($random(seed), pass == 0));
            store(lsu_pkg::SH, base + 2, top_bits($random(seed), pass == 0));
            for (int off = 0; off < 4; off++) begin
                load_check(lsu_pkg::LB, base + off);
                load_check(lsu_pkg::LBU, base + off);
                load_check(lsu_pkg::LH, base + off);
                load_check(lsu_pkg::LHU, base + off);
            end
        end
    endtask

    task automatic test_io();
        lsu_pkg::word_t pages [4];
        pages = '{{`LSU_LEDR_PAGE, 12'h000}, {`LSU_LEDG_PAGE, 12'h000},
                  {`LSU_HEXLO_PAGE, 12'h000}, {`LSU_HEXHI_PAGE, 12'h000}};
        for (int p = 0; p < 4; p++) begin
            store(lsu_pkg::SW, pages[p], $random(seed) | 32'h8080_8080);
            store(lsu_pkg::SH, pages[p] + 2, $random(seed));
            store(lsu_pkg::SB, pages[p] + 1, $random(seed));
            idle();
            check_board();
            load_check(lsu_pkg::LW, pages[p]);
            load_check(lsu_pkg::LBU, pages[p] + 3);
            load_check(lsu_pkg::LH, pages[p] + 2);
        end
    endtask

    task automatic test_sw_unmapped();
        lsu_pkg::word_t sw_addr;
        sw_addr = {`LSU_SW_PAGE, 12'h000};
        @(posedge clk);
        #1;
        io_sw = $random(seed);
        sw_m  = io_sw;   // Sampled at the next edge
        load_check(lsu_pkg::LB, sw_addr + 1);
        store(lsu_pkg::SW, sw_addr, $random(seed));
        store(lsu_pkg::SB, 32'h2000_0004, $random(seed));
        store(lsu_pkg::SH, 32'h1000_4002, $random(seed));
        store(lsu_pkg::SW, 32'h0000_8000, $random(seed));
        idle();
        check_board();
        load_check(lsu_pkg::LW, sw_addr);
        load_check(lsu_pkg::LW, 32'h2000_0004);
        load_check(lsu_pkg::LBU, 32'h1000_4001);
        load_check(lsu_pkg::LW, 32'h0000_8000);
    endtask

    initial begin
        seed     = 32'he6a2_96df;
        errors   = 0;
        checks   = 0;
        lsu_wren = 1'b0;
        lsu_addr = '0;
        st_data  = '0;
        io_sw    = '0;
        op       = lsu_pkg::LW;
        ledr_m   = '0;
        ledg_m   = '0;
        sw_m     = '0;
        for (int i = 0; i < 8; i++) hex_m[i] = '0;
        test_in_reset();
        wait_reset_release(reset_done);
        if (reset_done) begin
            test_reset();
            test_word_mem();
            test_partial();
            test_io();
            test_sw_unmapped();
        end
        finish_run();
    end

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int HALF_NS      = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_NS) o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_reset = 1'b0;   // Release just after an edge
    end

endmodule

// File: src/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_lsu_wren,
    input  lsu_pkg::word_t   i_lsu_addr,
    input  lsu_pkg::word_t   i_st_data,
    input  lsu_pkg::word_t   i_io_sw,
    input  lsu_pkg::mem_op_e i_type,
    output lsu_pkg::word_t   o_ld_data,
    output lsu_pkg::word_t   o_io_ledr,
    output lsu_pkg::word_t   o_io_ledg,
    output lsu_pkg::seg_t    o_io_hex0,
    output lsu_pkg::seg_t    o_io_hex1,
    output lsu_pkg::seg_t    o_io_hex2,
    output lsu_pkg::seg_t    o_io_hex3,
    output lsu_pkg::seg_t    o_io_hex4,
    output lsu_pkg::seg_t    o_io_hex5,
    output lsu_pkg::seg_t    o_io_hex6,
    output lsu_pkg::seg_t    o_io_hex7
);

    lsu_pkg::region_e region;
    lsu_pkg::strb_t   strb;
    lsu_pkg::word_t   wdata;
    lsu_pkg::word_t   mem_rdata;
    lsu_pkg::word_t   io_rdata;
    logic             mem_we;
    logic             ledr_we;
    logic             ledg_we;
    logic             hexlo_we;
    logic             hexhi_we;

    lsu_access_ctrl u_ctrl (
        .i_lsu_addr (i_lsu_addr),
        .i_type     (i_type),
        .i_st_data  (i_st_data),
        .i_lsu_wren (i_lsu_wren),
        .o_region   (region),
        .o_strb     (strb),
        .o_wdata    (wdata),
        .o_mem_we   (mem_we),
        .o_ledr_we  (ledr_we),
        .o_ledg_we  (ledg_we),
        .o_hexlo_we (hexlo_we),
        .o_hexhi_we (hexhi_we)
    );

    lsu_data_mem u_mem (
        .i_clk   (i_clk),
        .i_we    (mem_we),
        .i_addr  (i_lsu_addr),
        .i_strb  (strb),
        .i_wdata (wdata),
        .o_rdata (mem_rdata)
    );

    lsu_io_regs u_io (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_region   (region),
        .i_strb     (strb),
        .i_wdata    (wdata),
        .i_ledr_we  (ledr_we),
        .i_ledg_we  (ledg_we),
        .i_hexlo_we (hexlo_we),
        .i_hexhi_we (hexhi_we),
        .i_io_sw    (i_io_sw),
        .o_io_rdata (io_rdata),
        .o_io_ledr  (o_io_ledr),
        .o_io_ledg  (o_io_ledg),
        .o_io_hex0  (o_io_hex0),
        .o_io_hex1  (o_io_hex1),
        .o_io_hex2  (o_io_hex2),
        .o_io_hex3  (o_io_hex3),
        .o_io_hex4  (o_io_hex4),
        .o_io_hex5  (o_io_hex5),
        .o_io_hex6  (o_io_hex6),
        .o_io_hex7  (o_io_hex7)
    );

    lsu_load_extract u_ld (
        .i_reset     (i_reset),
        .i_region    (region),
        .i_type      (i_type),
        .i_byte_off  (i_lsu_addr[1:0]),
        .i_mem_rdata (mem_rdata),
        .i_io_rdata  (io_rdata),
        .o_ld_data   (o_ld_data)
    );

endmodule

// File: src/lsu_load_extract.sv
`timescale 1ns/10ps

module lsu_load_extract (
    input  logic             i_reset,
    input  lsu_pkg::region_e i_region,
    input  lsu_pkg::mem_op_e i_type,
    input  logic [1:0]       i_byte_off,
    input  lsu_pkg::word_t   i_mem_rdata,
    input  lsu_pkg::word_t   i_io_rdata,
    output lsu_pkg::word_t   o_ld_data
);

    lsu_pkg::word_t src_word;
    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    lsu_pkg::word_t ext_word;

    assign src_word = (i_region == lsu_pkg::REG_MEM) ? i_mem_rdata : i_io_rdata;

    assign byte_sel = src_word[8*i_byte_off +: 8];
    assign half_sel = i_byte_off[1] ? src_word[31:16] : src_word[15:0];

    // Sign or zero extension
    always_comb begin
        case (i_type)
            lsu_pkg::LB:  ext_word = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::LBU: ext_word = {24'b0, byte_sel};
            lsu_pkg::LH:  ext_word = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::LHU: ext_word = {16'b0, half_sel};
            default:      ext_word = src_word;
        endcase
    end

    always_comb begin
        if (i_reset) begin
            o_ld_data = '0;
        end else begin
            case (i_region)
                lsu_pkg::REG_NONE: o_ld_data = '0;
                lsu_pkg::REG_SW:   o_ld_data = src_word;  // Whole switch word for any type
                default:           o_ld_data = ext_word;
            endcase
        end
    end

endmodule

// File: src/lsu_io_regs.sv
`timescale 1ns/10ps

module lsu_io_regs (
    input  logic             i_clk,
    input  logic             i_reset,
    input  lsu_pkg::region_e i_region,
    input  lsu_pkg::strb_t   i_strb,
    input  lsu_pkg::word_t   i_wdata,
    input  logic             i_ledr_we,
    input  logic             i_ledg_we,
    input  logic             i_hexlo_we,
    input  logic             i_hexhi_we,
    input  lsu_pkg::word_t   i_io_sw,
    output lsu_pkg::word_t   o_io_rdata,
    output lsu_pkg::word_t   o_io_ledr,
    output lsu_pkg::word_t   o_io_ledg,
    output lsu_pkg::seg_t    o_io_hex0,
    output lsu_pkg::seg_t    o_io_hex1,
    output lsu_pkg::seg_t    o_io_hex2,
    output lsu_pkg::seg_t    o_io_hex3,
    output lsu_pkg::seg_t    o_io_hex4,
    output lsu_pkg::seg_t    o_io_hex5,
    output lsu_pkg::seg_t    o_io_hex6,
    output lsu_pkg::seg_t    o_io_hex7
);

    lsu_pkg::word_t       ledr_q;
    lsu_pkg::word_t       ledg_q;
    lsu_pkg::seg_t  [3:0] hexlo_q;   // HEX3..HEX0
    lsu_pkg::seg_t  [3:0] hexhi_q;   // HEX7..HEX4
    lsu_pkg::word_t       sw_q;

    function automatic lsu_pkg::word_t word_merge(lsu_pkg::word_t cur, lsu_pkg::word_t wd,
                                                  lsu_pkg::strb_t strb);
        lsu_pkg::word_t res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    // Bit 7 of each lane is dropped
    function automatic logic [27:0] seg_merge(logic [27:0] cur, lsu_pkg::word_t wd,
                                              lsu_pkg::strb_t strb);
        logic [27:0] res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[7*b +: 7] = wd[8*b +: 7];
        end
        return res;
    endfunction

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            ledr_q  <= '0;
            ledg_q  <= '0;
            hexlo_q <= '0;
            hexhi_q <= '0;
            sw_q    <= '0;
        end else begin
            if (i_ledr_we)  ledr_q  <= word_merge(ledr_q, i_wdata, i_strb);
            if (i_ledg_we)  ledg_q  <= word_merge(ledg_q, i_wdata, i_strb);
            if (i_hexlo_we) hexlo_q <= seg_merge(hexlo_q, i_wdata, i_strb);
            if (i_hexhi_we) hexhi_q <= seg_merge(hexhi_q, i_wdata, i_strb);
            sw_q <= i_io_sw;   // One-stage sample
        end
    end

    always_comb begin
        case (i_region)
            lsu_pkg::REG_LEDR:  o_io_rdata = ledr_q;
            lsu_pkg::REG_LEDG:  o_io_rdata = ledg_q;
            lsu_pkg::REG_HEXLO: o_io_rdata = {1'b0, hexlo_q[3], 1'b0, hexlo_q[2],
                                              1'b0, hexlo_q[1], 1'b0, hexlo_q[0]};
            lsu_pkg::REG_HEXHI: o_io_rdata = {1'b0, hexhi_q[3], 1'b0, hexhi_q[2],
                                              1'b0, hexhi_q[1], 1'b0, hexhi_q[0]};
            lsu_pkg::REG_SW:    o_io_rdata = sw_q;
            default:            o_io_rdata = '0;
        endcase
    end

    assign o_io_ledr = ledr_q;
    assign o_io_ledg = ledg_q;
    assign o_io_hex0 = hexlo_q[0];
    assign o_io_hex1 = hexlo_q[1];
    assign o_io_hex2 = hexlo_q[2];
    assign o_io_hex3 = hexlo_q[3];
    assign o_io_hex4 = hexhi_q[0];
    assign o_io_hex5 = hexhi_q[1];
    assign o_io_hex6 = hexhi_q[2];
    assign o_io_hex7 = hexhi_q[3];

endmodule

// File: src/lsu_data_mem.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_data_mem #(
    parameter int DEPTH = `LSU_MEM_DEPTH
) (
    input  logic           i_clk,
    input  logic           i_we,
    input  lsu_pkg::word_t i_addr,
    input  lsu_pkg::strb_t i_strb,
    input  lsu_pkg::word_t i_wdata,
    output lsu_pkg::word_t o_rdata
);

    localparam int AW = $clog2(DEPTH);

    lsu_pkg::word_t mem [DEPTH];
    logic [AW-1:0]  idx;

    // Word index, upper bits alias
    assign idx = i_addr[AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_strb[b]) begin
                    mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    assign o_rdata = mem[idx];  // Old data during a same-cycle store

endmodule

// File: src/lsu_access_ctrl.sv
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_access_ctrl (
    input  lsu_pkg::word_t   i_lsu_addr,
    input  lsu_pkg::mem_op_e i_type,
    input  lsu_pkg::word_t   i_st_data,
    input  logic             i_lsu_wren,
    output lsu_pkg::region_e o_region,
    output lsu_pkg::strb_t   o_strb,
    output lsu_pkg::word_t   o_wdata,
    output logic             o_mem_we,
    output logic             o_ledr_we,
    output logic             o_ledg_we,
    output logic             o_hexlo_we,
    output logic             o_hexhi_we
);

    logic [19:0] page;
    logic        is_store;
    logic        wr;

    assign page = i_lsu_addr[`LSU_PAGE_MSB:`LSU_PAGE_LSB];

    // Address map decode
    always_comb begin
        if (i_lsu_addr[31 -: `LSU_MEM_HI_BITS] == '0) begin
            o_region = lsu_pkg::REG_MEM;
        end else begin
            case (page)
                `LSU_LEDR_PAGE:  o_region = lsu_pkg::REG_LEDR;
                `LSU_LEDG_PAGE:  o_region = lsu_pkg::REG_LEDG;
                `LSU_HEXLO_PAGE: o_region = lsu_pkg::REG_HEXLO;
                `LSU_HEXHI_PAGE: o_region = lsu_pkg::REG_HEXHI;
                `LSU_SW_PAGE:    o_region = lsu_pkg::REG_SW;
                default:         o_region = lsu_pkg::REG_NONE;
            endcase
        end
    end

    // Lane strobes and replicated store data
    always_comb begin
        is_store = 1'b1;
        o_wdata  = i_st_data;
        case (i_type)
            lsu_pkg::SW: o_strb = 4'b1111;
            lsu_pkg::SH: begin
                o_strb  = i_lsu_addr[1] ? 4'b1100 : 4'b0011;
                o_wdata = {2{i_st_data[15:0]}};
            end
            lsu_pkg::SB: begin
                o_strb  = 4'b0001 << i_lsu_addr[1:0];
                o_wdata = {4{i_st_data[7:0]}};
            end
            default: begin
                o_strb   = 4'b0000;   // Loads
                is_store = 1'b0;
            end
        endcase
    end

    assign wr = i_lsu_wren & is_store;

    assign o_mem_we   = wr & (o_region == lsu_pkg::REG_MEM);
    assign o_ledr_we  = wr & (o_region == lsu_pkg::REG_LEDR);
    assign o_ledg_we  = wr & (o_region == lsu_pkg::REG_LEDG);
    assign o_hexlo_we = wr & (o_region == lsu_pkg::REG_HEXLO);
    assign o_hexhi_we = wr & (o_region == lsu_pkg::REG_HEXHI);  // Switch page has no strobe

endmodule

// File: src/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;   // Bit n enables byte n
    typedef logic [6:0]  seg_t;

    // Encoding follows the core's decoder
    typedef enum logic [2:0] {
        LW  = 3'b000,
        SW  = 3'b001,
        LB  = 3'b010,
        LBU = 3'b011,
        LH  = 3'b100,
        LHU = 3'b101,
        SB  = 3'b110,
        SH  = 3'b111
    } mem_op_e;

    typedef enum logic [2:0] {
        REG_NONE  = 3'd0,
        REG_MEM   = 3'd1,
        REG_LEDR  = 3'd2,
        REG_LEDG  = 3'd3,
        REG_HEXLO = 3'd4,
        REG_HEXHI = 3'd5,
        REG_SW    = 3'd6
    } region_e;

endpackage

// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data memory size in 32-bit words
`define LSU_MEM_DEPTH    256

// Memory region is 0x0000_0000..0x0000_7FFF
`define LSU_MEM_HI_BITS  17

// I/O pages, address bits 31..12
`define LSU_LEDR_PAGE    20'h10000
`define LSU_LEDG_PAGE    20'h10001
`define LSU_HEXLO_PAGE   20'h10002
`define LSU_HEXHI_PAGE   20'h10003
`define LSU_SW_PAGE      20'h10010

// Page field position
`define LSU_PAGE_MSB     31
`define LSU_PAGE_LSB     12

`endif
